/* logic/rasterSetupPkg.sv */
`default_nettype none

package rasterSetupPkg;

	// ----------------------------------------
	// Coordinate formats
	// ----------------------------------------

	// Signed screen coordinate
	// Vertices, query pixels and box bounds
	typedef logic signed [11:0] coord_t;

	// Drawing area bound, always positive
	typedef logic [9:0] areaCoord_t;

	// ----------------------------------------
	// Arithmetic results
	// ----------------------------------------

	// Edge function value, 12b x 12b product plus bias
	// Only the sign bit matters downstream
	typedef logic signed [22:0] edgeVal_t;

	// Line stepper decision term
	// Holds 2*minor + 1 and the 2*minor - 2*major update
	typedef logic signed [13:0] lineErr_t;

	// ----------------------------------------
	// Span limits for early reject
	// ----------------------------------------

	// Widest accepted box, plus one
	localparam int MAX_SPAN_X = 1024;

	// Tallest accepted box, plus one
	localparam int MAX_SPAN_Y = 512;

endpackage

`default_nettype wire

/* logic/triangleSetup.sv */
`timescale 1ns/1ns
`default_nettype none

module triangleSetup (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic                        i_setupStrobe,
	input  logic                        i_isLine,
	input  rasterSetupPkg::coord_t      i_x0,
	input  rasterSetupPkg::coord_t      i_y0,
	input  rasterSetupPkg::coord_t      i_x1,
	input  rasterSetupPkg::coord_t      i_y1,
	input  rasterSetupPkg::coord_t      i_x2,
	input  rasterSetupPkg::coord_t      i_y2,
	input  rasterSetupPkg::areaCoord_t  i_areaX0,
	input  rasterSetupPkg::areaCoord_t  i_areaY0,
	input  rasterSetupPkg::areaCoord_t  i_areaX1,
	input  rasterSetupPkg::areaCoord_t  i_areaY1,
	output logic                        o_setupDone,
	output logic                        o_reject,
	output rasterSetupPkg::coord_t      o_clipMinX,
	output rasterSetupPkg::coord_t      o_clipMaxX,
	output rasterSetupPkg::coord_t      o_clipMinY,
	output rasterSetupPkg::coord_t      o_clipMaxY,
	output rasterSetupPkg::coord_t      o_areaX0,
	output rasterSetupPkg::coord_t      o_areaX1,
	output rasterSetupPkg::coord_t      o_areaY0,
	output rasterSetupPkg::coord_t      o_areaY1,
	output rasterSetupPkg::coord_t      o_vx0,
	output rasterSetupPkg::coord_t      o_vy0,
	output rasterSetupPkg::coord_t      o_vx1,
	output rasterSetupPkg::coord_t      o_vy1,
	output rasterSetupPkg::coord_t      o_vx2,
	output rasterSetupPkg::coord_t      o_vy2,
	output rasterSetupPkg::coord_t      o_e,
	output rasterSetupPkg::coord_t      o_f,
	output rasterSetupPkg::coord_t      o_negPreA,
	output rasterSetupPkg::coord_t      o_preB,
	output rasterSetupPkg::coord_t      o_c,
	output rasterSetupPkg::coord_t      o_negD,
	output logic                        o_bias0,
	output logic                        o_bias1,
	output logic                        o_bias2,
	output logic                        o_isLine
);
	import rasterSetupPkg::*;

	function automatic coord_t minOf(coord_t a, coord_t b);
		return (a < b) ? a : b;
	endfunction

	function automatic coord_t maxOf(coord_t a, coord_t b);
		return (a > b) ? a : b;
	endfunction

	// ----------------------------------------
	// Stage 1, capture on strobe
	// ----------------------------------------
	logic       capValid;
	logic       capIsLine;
	coord_t     capX0, capY0, capX1, capY1, capX2, capY2;
	areaCoord_t capAreaX0, capAreaY0, capAreaX1, capAreaY1;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			capValid <= 1'b0;
		end else begin
			capValid <= i_setupStrobe;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_setupStrobe) begin
			capIsLine <= i_isLine;
			capX0     <= i_x0;
			capY0     <= i_y0;
			capX1     <= i_x1;
			capY1     <= i_y1;
			capX2     <= i_x2;
			capY2     <= i_y2;
			capAreaX0 <= i_areaX0;
			capAreaY0 <= i_areaY0;
			capAreaX1 <= i_areaX1;
			capAreaY1 <= i_areaY1;
		end
	end

	// Area bounds widened to the signed coordinate format
	coord_t areaX0, areaY0, areaX1, areaY1;
	assign areaX0 = coord_t'({2'b00, capAreaX0});
	assign areaY0 = coord_t'({2'b00, capAreaY0});
	assign areaX1 = coord_t'({2'b00, capAreaX1});
	assign areaY1 = coord_t'({2'b00, capAreaY1});

	// Edge differences, negated forms taken directly
	coord_t e, f, negPreA, preB, c, negD;
	assign e       = capX2 - capX1;
	assign f       = capY1 - capY2;
	assign negPreA = capX0 - capX2;
	assign preB    = capY2 - capY0;
	assign c       = capX1 - capX0;
	assign negD    = capY0 - capY1;

	// Top-left rule per edge
	logic bias0, bias1, bias2;
	assign bias0 = f[11] | ((f == '0) & e[11]);
	assign bias1 = preB[11] | ((preB == '0) & negPreA[11]);
	assign bias2 = negD[11] | ((negD == '0) & c[11]);

	// Box from v0/v1, vertex 2 only for triangles
	coord_t minX01, maxX01, minY01, maxY01;
	coord_t minX, maxX, minY, maxY;
	assign minX01 = minOf(capX0, capX1);
	assign maxX01 = maxOf(capX0, capX1);
	assign minY01 = minOf(capY0, capY1);
	assign maxY01 = maxOf(capY0, capY1);
	assign minX   = capIsLine ? minX01 : minOf(minX01, capX2);
	assign maxX   = capIsLine ? maxX01 : maxOf(maxX01, capX2);
	assign minY   = capIsLine ? minY01 : minOf(minY01, capY2);
	assign maxY   = capIsLine ? maxY01 : maxOf(maxY01, capY2);

	// Spans need one extra bit, never negative
	logic [12:0] spanX, spanY;
	assign spanX = {maxX[11], maxX} - {minX[11], minX};
	assign spanY = {maxY[11], maxY} - {minY[11], minY};

	// Too large, or fully outside the area on any side
	logic reject;
	assign reject = (spanX >= 13'(MAX_SPAN_X)) | (spanY >= 13'(MAX_SPAN_Y))
		| (maxX < areaX0) | (maxY < areaY0)
		| (minX > areaX1) | (minY > areaY1);

	// ----------------------------------------
	// Stage 2, results and done
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_setupDone <= 1'b0;
			o_reject    <= 1'b0;
			o_isLine    <= 1'b0;
		end else begin
			o_setupDone <= capValid;
			if (capValid) begin
				o_reject <= reject;
				o_isLine <= capIsLine;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (capValid) begin
			// Inclusive intersection of box and area
			o_clipMinX <= maxOf(minX, areaX0);
			o_clipMaxX <= minOf(maxX, areaX1);
			o_clipMinY <= maxOf(minY, areaY0);
			o_clipMaxY <= minOf(maxY, areaY1);
			o_areaX0   <= areaX0;
			o_areaX1   <= areaX1;
			o_areaY0   <= areaY0;
			o_areaY1   <= areaY1;
			o_vx0      <= capX0;
			o_vy0      <= capY0;
			o_vx1      <= capX1;
			o_vy1      <= capY1;
			o_vx2      <= capX2;
			o_vy2      <= capY2;
			o_e        <= e;
			o_f        <= f;
			o_negPreA  <= negPreA;
			o_preB     <= preB;
			o_c        <= c;
			o_negD     <= negD;
			o_bias0    <= bias0;
			o_bias1    <= bias1;
			o_bias2    <= bias2;
		end
	end

endmodule

`default_nettype wire

/* logic/pixelBoxTest.sv */
`timescale 1ns/1ns
`default_nettype none

module pixelBoxTest (
	input  rasterSetupPkg::coord_t i_pixelX,
	input  rasterSetupPkg::coord_t i_pixelY,
	input  rasterSetupPkg::coord_t i_clipMinX,
	input  rasterSetupPkg::coord_t i_clipMaxX,
	input  rasterSetupPkg::coord_t i_clipMinY,
	input  rasterSetupPkg::coord_t i_clipMaxY,
	input  rasterSetupPkg::coord_t i_areaX0,
	input  rasterSetupPkg::coord_t i_areaX1,
	input  rasterSetupPkg::coord_t i_areaY0,
	input  rasterSetupPkg::coord_t i_areaY1,
	output logic                   o_inBoxL,
	output logic                   o_inBoxR,
	output logic                   o_lineInside
);
	import rasterSetupPkg::*;

	// Inclusive on both ends
	function automatic logic inRange(coord_t v, coord_t lo, coord_t hi);
		return (v >= lo) & (v <= hi);
	endfunction

	// Even/odd members of the pair
	coord_t lPixX, rPixX, linePixX;
	assign lPixX = coord_t'({i_pixelX[11:1], 1'b0});
	assign rPixX = coord_t'({i_pixelX[11:1], 1'b1});

	// ----------------------------------------
	// Triangle, clipped box
	// ----------------------------------------
	logic clipRowOk;
	assign clipRowOk = inRange(i_pixelY, i_clipMinY, i_clipMaxY);
	assign o_inBoxL  = clipRowOk & inRange(lPixX, i_clipMinX, i_clipMaxX);
	assign o_inBoxR  = clipRowOk & inRange(rPixX, i_clipMinX, i_clipMaxX);

	// ----------------------------------------
	// Line, drawing area only
	// ----------------------------------------

	// Pair member picked by requested parity
	assign linePixX = i_pixelX[0] ? rPixX : lPixX;

	logic areaRowOk;
	assign areaRowOk    = inRange(i_pixelY, i_areaY0, i_areaY1);
	assign o_lineInside = areaRowOk & inRange(linePixX, i_areaX0, i_areaX1);

endmodule

`default_nettype wire

/* logic/coverageStage.sv */
`timescale 1ns/1ns
`default_nettype none

module coverageStage (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_queryStrobe,
	input  rasterSetupPkg::coord_t i_pixelX,
	input  rasterSetupPkg::coord_t i_pixelY,
	input  rasterSetupPkg::coord_t i_vx0,
	input  rasterSetupPkg::coord_t i_vy0,
	input  rasterSetupPkg::coord_t i_vx1,
	input  rasterSetupPkg::coord_t i_vy1,
	input  rasterSetupPkg::coord_t i_vx2,
	input  rasterSetupPkg::coord_t i_vy2,
	input  rasterSetupPkg::coord_t i_e,
	input  rasterSetupPkg::coord_t i_f,
	input  rasterSetupPkg::coord_t i_negPreA,
	input  rasterSetupPkg::coord_t i_preB,
	input  rasterSetupPkg::coord_t i_c,
	input  rasterSetupPkg::coord_t i_negD,
	input  logic                   i_bias0,
	input  logic                   i_bias1,
	input  logic                   i_bias2,
	input  rasterSetupPkg::coord_t i_clipMinX,
	input  rasterSetupPkg::coord_t i_clipMaxX,
	input  rasterSetupPkg::coord_t i_clipMinY,
	input  rasterSetupPkg::coord_t i_clipMaxY,
	input  rasterSetupPkg::coord_t i_areaX0,
	input  rasterSetupPkg::coord_t i_areaX1,
	input  rasterSetupPkg::coord_t i_areaY0,
	input  rasterSetupPkg::coord_t i_areaY1,
	input  logic                   i_isLine,
	output logic                   o_queryDone,
	output logic                   o_validL,
	output logic                   o_validR,
	output logic                   o_lineInside
);
	import rasterSetupPkg::*;

	// All >= 0 (one winding) or all < 0 (the other)
	function automatic logic sameSign(edgeVal_t a, edgeVal_t b, edgeVal_t c);
		logic sa, sb, sc;
		sa = a[$bits(edgeVal_t)-1];
		sb = b[$bits(edgeVal_t)-1];
		sc = c[$bits(edgeVal_t)-1];
		return (!sa & !sb & !sc) | (sa & sb & sc);
	endfunction

	// ----------------------------------------
	// Edge functions, left pixel
	// ----------------------------------------
	coord_t lPixX;
	coord_t dxV0, dyV0, dxV1, dyV1, dxV2, dyV2;
	assign lPixX = coord_t'({i_pixelX[11:1], 1'b0});
	assign dxV0  = lPixX - i_vx0;
	assign dyV0  = i_pixelY - i_vy0;
	assign dxV1  = lPixX - i_vx1;
	assign dyV1  = i_pixelY - i_vy1;
	assign dxV2  = lPixX - i_vx2;
	assign dyV2  = i_pixelY - i_vy2;

	edgeVal_t w0L, w1L, w2L, w0R, w1R, w2R;
	assign w0L = i_e * dyV1 + i_f * dxV1 - edgeVal_t'(i_bias0);
	assign w1L = i_negPreA * dyV2 + i_preB * dxV2 - edgeVal_t'(i_bias1);
	assign w2L = i_c * dyV0 + i_negD * dxV0 - edgeVal_t'(i_bias2);

	// Right pixel is one step in X, add the X coefficient
	assign w0R = w0L + edgeVal_t'(i_f);
	assign w1R = w1L + edgeVal_t'(i_preB);
	assign w2R = w2L + edgeVal_t'(i_negD);

	// ----------------------------------------
	// Box flags and coverage
	// ----------------------------------------
	logic inBoxL, inBoxR, lineInside;

	pixelBoxTest boxTest (
		.i_pixelX     (i_pixelX),
		.i_pixelY     (i_pixelY),
		.i_clipMinX   (i_clipMinX),
		.i_clipMaxX   (i_clipMaxX),
		.i_clipMinY   (i_clipMinY),
		.i_clipMaxY   (i_clipMaxY),
		.i_areaX0     (i_areaX0),
		.i_areaX1     (i_areaX1),
		.i_areaY0     (i_areaY0),
		.i_areaY1     (i_areaY1),
		.o_inBoxL     (inBoxL),
		.o_inBoxR     (inBoxR),
		.o_lineInside (lineInside)
	);

	logic coverL, coverR;
	assign coverL = sameSign(w0L, w1L, w2L) & inBoxL & !i_isLine;
	assign coverR = sameSign(w0R, w1R, w2R) & inBoxR & !i_isLine;

	// One cycle, results held until next query
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_queryDone  <= 1'b0;
			o_validL     <= 1'b0;
			o_validR     <= 1'b0;
			o_lineInside <= 1'b0;
		end else begin
			o_queryDone <= i_queryStrobe;
			if (i_queryStrobe) begin
				o_validL     <= coverL;
				o_validR     <= coverR;
				o_lineInside <= lineInside;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/lineStepper.sv */
`timescale 1ns/1ns
`default_nettype none

module lineStepper (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_lineStart,
	input  logic                   i_lineStep,
	input  rasterSetupPkg::coord_t i_x0,
	input  rasterSetupPkg::coord_t i_y0,
	input  rasterSetupPkg::coord_t i_x1,
	input  rasterSetupPkg::coord_t i_y1,
	output rasterSetupPkg::coord_t o_lineX,
	output rasterSetupPkg::coord_t o_lineY
);
	import rasterSetupPkg::*;

	// ----------------------------------------
	// Direction and spans
	// ----------------------------------------
	coord_t      c, d;
	logic        negX, negY;
	logic [11:0] absX, absY, major, minor;
	logic        swapAxis;

	assign c    = i_x1 - i_x0;
	assign d    = i_y1 - i_y0;
	assign negX = c[11];
	assign negY = d[11];
	assign absX = negX ? -c : c;
	assign absY = negY ? -d : d;

	// Ties stay X major
	assign swapAxis = absY > absX;
	assign major    = swapAxis ? absY : absX;
	assign minor    = swapAxis ? absX : absY;

	lineErr_t err, errNext, startErr, majorErr, majorTwice, minorTwice;
	assign majorErr   = lineErr_t'(major);
	assign majorTwice = lineErr_t'({major, 1'b0});
	assign minorTwice = lineErr_t'({minor, 1'b0});
	assign startErr   = minorTwice + lineErr_t'(!swapAxis);

	// Error past the major span moves the minor axis too
	logic diag, moveX, moveY;
	assign diag    = err > majorErr;
	assign moveX   = !swapAxis | diag;
	assign moveY   = swapAxis | diag;
	assign errNext = diag ? (err + minorTwice - majorTwice) : (err + minorTwice);

	coord_t stepX, stepY;
	assign stepX = negX ? coord_t'(-1) : coord_t'(1);
	assign stepY = negY ? coord_t'(-1) : coord_t'(1);

	// ----------------------------------------
	// Position and error registers
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_lineX <= '0;
			o_lineY <= '0;
			err     <= '0;
		end else if (i_lineStart) begin
			o_lineX <= i_x0;
			o_lineY <= i_y0;
			err     <= startErr;
		end else if (i_lineStep) begin
			if (moveX) begin
				o_lineX <= o_lineX + stepX;
			end
			if (moveY) begin
				o_lineY <= o_lineY + stepY;
			end
			err <= errNext;
		end
	end

endmodule

`default_nettype wire

/* logic/rasterSetupUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module rasterSetupUnit (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_setupStrobe,
	input  logic                       i_isLine,
	input  rasterSetupPkg::coord_t     i_x0,
	input  rasterSetupPkg::coord_t     i_y0,
	input  rasterSetupPkg::coord_t     i_x1,
	input  rasterSetupPkg::coord_t     i_y1,
	input  rasterSetupPkg::coord_t     i_x2,
	input  rasterSetupPkg::coord_t     i_y2,
	input  rasterSetupPkg::areaCoord_t i_areaX0,
	input  rasterSetupPkg::areaCoord_t i_areaY0,
	input  rasterSetupPkg::areaCoord_t i_areaX1,
	input  rasterSetupPkg::areaCoord_t i_areaY1,
	input  logic                       i_queryStrobe,
	input  rasterSetupPkg::coord_t     i_pixelX,
	input  rasterSetupPkg::coord_t     i_pixelY,
	input  logic                       i_lineStart,
	input  logic                       i_lineStep,
	output logic                       o_setupDone,
	output logic                       o_reject,
	output rasterSetupPkg::coord_t     o_clipMinX,
	output rasterSetupPkg::coord_t     o_clipMaxX,
	output rasterSetupPkg::coord_t     o_clipMinY,
	output rasterSetupPkg::coord_t     o_clipMaxY,
	output logic                       o_queryDone,
	output logic                       o_validL,
	output logic                       o_validR,
	output logic                       o_lineInside,
	output rasterSetupPkg::coord_t     o_lineX,
	output rasterSetupPkg::coord_t     o_lineY
);
	import rasterSetupPkg::*;

	// Registered setup results
	coord_t vx0, vy0, vx1, vy1, vx2, vy2;
	coord_t areaX0, areaX1, areaY0, areaY1;
	coord_t e, f, negPreA, preB, c, negD;
	logic   bias0, bias1, bias2;
	logic   isLine;

	triangleSetup setup (
		.i_clk (i_clk), .i_rst (i_rst),
		.i_setupStrobe (i_setupStrobe), .i_isLine (i_isLine),
		.i_x0 (i_x0), .i_y0 (i_y0), .i_x1 (i_x1), .i_y1 (i_y1),
		.i_x2 (i_x2), .i_y2 (i_y2),
		.i_areaX0 (i_areaX0), .i_areaY0 (i_areaY0),
		.i_areaX1 (i_areaX1), .i_areaY1 (i_areaY1),
		.o_setupDone (o_setupDone), .o_reject (o_reject),
		.o_clipMinX (o_clipMinX), .o_clipMaxX (o_clipMaxX),
		.o_clipMinY (o_clipMinY), .o_clipMaxY (o_clipMaxY),
		.o_areaX0 (areaX0), .o_areaX1 (areaX1),
		.o_areaY0 (areaY0), .o_areaY1 (areaY1),
		.o_vx0 (vx0), .o_vy0 (vy0), .o_vx1 (vx1), .o_vy1 (vy1),
		.o_vx2 (vx2), .o_vy2 (vy2),
		.o_e (e), .o_f (f), .o_negPreA (negPreA), .o_preB (preB),
		.o_c (c), .o_negD (negD),
		.o_bias0 (bias0), .o_bias1 (bias1), .o_bias2 (bias2),
		.o_isLine (isLine)
	);

	// Pixel pair query, one cycle
	coverageStage coverage (
		.i_clk (i_clk), .i_rst (i_rst),
		.i_queryStrobe (i_queryStrobe),
		.i_pixelX (i_pixelX), .i_pixelY (i_pixelY),
		.i_vx0 (vx0), .i_vy0 (vy0), .i_vx1 (vx1), .i_vy1 (vy1),
		.i_vx2 (vx2), .i_vy2 (vy2),
		.i_e (e), .i_f (f), .i_negPreA (negPreA), .i_preB (preB),
		.i_c (c), .i_negD (negD),
		.i_bias0 (bias0), .i_bias1 (bias1), .i_bias2 (bias2),
		.i_clipMinX (o_clipMinX), .i_clipMaxX (o_clipMaxX),
		.i_clipMinY (o_clipMinY), .i_clipMaxY (o_clipMaxY),
		.i_areaX0 (areaX0), .i_areaX1 (areaX1),
		.i_areaY0 (areaY0), .i_areaY1 (areaY1),
		.i_isLine (isLine),
		.o_queryDone (o_queryDone), .o_validL (o_validL),
		.o_validR (o_validR), .o_lineInside (o_lineInside)
	);

	// Walks from captured v0 toward v1
	lineStepper stepper (
		.i_clk (i_clk), .i_rst (i_rst),
		.i_lineStart (i_lineStart), .i_lineStep (i_lineStep),
		.i_x0 (vx0), .i_y0 (vy0), .i_x1 (vx1), .i_y1 (vy1),
		.o_lineX (o_lineX), .o_lineY (o_lineY)
	);

endmodule

`default_nettype wire

/* tb/rasterSetupUnit_props.sv */
`timescale 1ns/1ns
`default_nettype none

module rasterSetupProps (
	input logic i_clk,
	input logic i_rst,
	input logic i_setupStrobe,
	input logic i_queryStrobe,
	input logic i_setupDone,
	input logic i_queryDone
);

	// Capture stage plus result stage
	property setupLatency;
		@(posedge i_clk) disable iff (i_rst)
		i_setupDone == $past(i_setupStrobe, 2);
	endproperty

	// Single result register
	property queryLatency;
		@(posedge i_clk) disable iff (i_rst)
		i_queryDone == $past(i_queryStrobe, 1);
	endproperty

	// Done pulses held low once reset has taken effect
	property quietInReset;
		@(posedge i_clk)
		(i_rst && $past(i_rst)) |-> (!i_setupDone && !i_queryDone);
	endproperty

	assert property (setupLatency)
		else $error("o_setupDone is not two cycles after i_setupStrobe");
	assert property (queryLatency)
		else $error("o_queryDone is not one cycle after i_queryStrobe");
	assert property (quietInReset)
		else $error("done pulse seen during reset");

endmodule

bind rasterSetupUnit rasterSetupProps props (
	.i_clk         (i_clk),
	.i_rst         (i_rst),
	.i_setupStrobe (i_setupStrobe),
	.i_queryStrobe (i_queryStrobe),
	.i_setupDone   (o_setupDone),
	.i_queryDone   (o_queryDone)
);

`default_nettype wire

/* tb/rasterSetupTb.sv */
`timescale 1ns/1ns
`default_nettype none

module rasterSetupTb;
	import rasterSetupPkg::*;

	localparam int CLK_PERIOD  = 10;
	localparam int NUM_ENTRIES = 16;
	localparam int NUM_RAND    = 6;
	localparam int NUM_QUERIES = 2 + NUM_RAND;
	localparam int SETUP_WAIT  = 8;
	// Room for setup, back-to-back queries and a walk of up to 30 steps
	localparam int CYCLES_PER_ENTRY = 80;
	localparam int WATCHDOG_NS = (NUM_ENTRIES * CYCLES_PER_ENTRY + 10) * CLK_PERIOD;

	// Primitive, area, expected reject and clip, two fixed query pixels
	typedef struct packed {
		int isLine;
		int x0, y0, x1, y1, x2, y2;
		int ax0, ay0, ax1, ay1;
		int rej;
		int cMinX, cMaxX, cMinY, cMaxY;
		int qx0, qy0, qx1, qy1;
	} primEntry_t;

	// ----------------------------------------
	// Stimulus table
	// ----------------------------------------
	// mode, v0 v1 v2, area, reject, clip minX maxX minY maxY, query pixels
	primEntry_t primTable [NUM_ENTRIES] = '{
		// Both windings over the same box
		'{0, 10, 10, 40, 12, 20, 40, 0, 0, 100, 100, 0, 10, 40, 10, 40, 20, 20, 11, 10},
		'{0, 10, 10, 20, 40, 40, 12, 0, 0, 100, 100, 0, 10, 40, 10, 40, 25, 25, 39, 12},
		// Box wider than the area
		'{0, -20, 5, 60, 5, 20, 70, 0, 0, 50, 50, 0, 0, 50, 5, 50, 0, 6, 50, 20},
		// Pair sharing the diagonal edge
		'{0, 0, 0, 16, 0, 0, 16, 0, 0, 63, 63, 0, 0, 16, 0, 16, 8, 8, 16, 0},
		'{0, 16, 0, 16, 16, 0, 16, 0, 0, 63, 63, 0, 0, 16, 0, 16, 8, 8, 15, 1},
		// Width 1024, height 512
		'{0, -100, 0, 924, 10, 0, 20, 0, 0, 1023, 511, 1, 0, 924, 0, 20, 0, 5, 100, 10},
		'{0, 0, -10, 10, 502, 5, 0, 0, 0, 1023, 511, 1, 0, 10, 0, 502, 4, 4, 5, 100},
		// Fully left, right, above, below
		'{0, 0, 0, 10, 0, 5, 10, 20, 0, 50, 50, 1, 20, 10, 0, 10, 4, 2, 20, 2},
		'{0, 60, 0, 70, 0, 65, 10, 0, 0, 50, 50, 1, 60, 50, 0, 10, 64, 2, 50, 2},
		'{0, 0, 0, 10, 0, 5, 10, 0, 20, 50, 50, 1, 0, 10, 20, 10, 4, 2, 4, 20},
		'{0, 0, 60, 10, 60, 5, 70, 0, 0, 50, 50, 1, 0, 10, 60, 50, 4, 62, 4, 50},
		// Lines with v2 ignored
		'{1, 5, 5, 30, 12, 1100, 500, 0, 0, 20, 20, 0, 5, 20, 5, 12, 21, 6, 20, 6},
		'{1, 30, 40, 22, 10, 0, 0, 0, 0, 63, 63, 0, 22, 30, 10, 40, 23, 5, 23, 64},
		'{1, 0, 0, 12, 12, 0, 0, 0, 0, 63, 63, 0, 0, 12, 0, 12, 3, 3, 0, 0},
		'{1, 40, 20, 10, 25, 0, 0, 0, 0, 63, 63, 0, 10, 40, 20, 25, 11, 21, -1, 21},
		'{1, 0, 0, 1100, 0, 0, 0, 0, 0, 1023, 511, 1, 0, 1023, 0, 0, 5, 0, 1030, 0}
	};

	logic       i_clk, i_rst;
	logic       i_setupStrobe, i_isLine, i_queryStrobe, i_lineStart, i_lineStep;
	coord_t     i_x0, i_y0, i_x1, i_y1, i_x2, i_y2, i_pixelX, i_pixelY;
	areaCoord_t i_areaX0, i_areaY0, i_areaX1, i_areaY1;
	logic       o_setupDone, o_reject, o_queryDone, o_validL, o_validR, o_lineInside;
	coord_t     o_clipMinX, o_clipMaxX, o_clipMinY, o_clipMaxY, o_lineX, o_lineY;

	int          errorCount;
	int          checkCount;
	logic [15:0] lfsrState;

	rasterSetupUnit DUT (.*);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	// ----------------------------------------
	// Reference model and helpers
	// ----------------------------------------

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit
	task automatic drawBits(input int n, output int val);
		int b;
		val = 0;
		for (b = 0; b < n; b++) begin
			lfsrState = lfsrNext(lfsrState);
			val = (val << 1) | int'(lfsrState[0]);
		end
	endtask

	function automatic bit inSpan(int v, int lo, int hi);
		return (v >= lo) && (v <= hi);
	endfunction

	// Same-sign edge rule with top-left bias and the clip
	function automatic bit modelCovered(primEntry_t p, int px, int py);
		int e, f, c, d, preA, preB;
		int t0, t1, t2, w0, w1, w2;
		bit inClip;
		e    = p.x2 - p.x1;
		f    = p.y1 - p.y2;
		c    = p.x1 - p.x0;
		d    = p.y1 - p.y0;
		preA = p.x2 - p.x0;
		preB = p.y2 - p.y0;
		t0   = (f < 0 || (f == 0 && e < 0)) ? 1 : 0;
		t1   = (preB < 0 || (preB == 0 && -preA < 0)) ? 1 : 0;
		t2   = (-d < 0 || (-d == 0 && c < 0)) ? 1 : 0;
		w0   = e * (py - p.y1) + f * (px - p.x1) - t0;
		w1   = -preA * (py - p.y2) + preB * (px - p.x2) - t1;
		w2   = c * (py - p.y0) - d * (px - p.x0) - t2;
		inClip = inSpan(px, p.cMinX, p.cMaxX) && inSpan(py, p.cMinY, p.cMaxY);
		if (p.isLine != 0 || !inClip) begin
			return 1'b0;
		end
		return (w0 >= 0 && w1 >= 0 && w2 >= 0) || (w0 < 0 && w1 < 0 && w2 < 0);
	endfunction

	// Parity-matched member of the pair is the requested pixel itself
	function automatic bit lineInsideRef(primEntry_t p, int px, int py);
		return inSpan(px, p.ax0, p.ax1) && inSpan(py, p.ay0, p.ay1);
	endfunction

	task automatic checkValue(input string name, input int got, input int expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("error %s: got %h, expected %h", name, got, expected);
		end
	endtask

	// ----------------------------------------
	// Stimulus tasks
	// ----------------------------------------
	task automatic applySetup(input primEntry_t p);
		int waited;
		i_setupStrobe = 1'b1;
		i_isLine      = p.isLine[0];
		i_x0          = p.x0[11:0];
		i_y0          = p.y0[11:0];
		i_x1          = p.x1[11:0];
		i_y1          = p.y1[11:0];
		i_x2          = p.x2[11:0];
		i_y2          = p.y2[11:0];
		i_areaX0      = p.ax0[9:0];
		i_areaY0      = p.ay0[9:0];
		i_areaX1      = p.ax1[9:0];
		i_areaY1      = p.ay1[9:0];
		waited        = 0;
		do begin
			@(negedge i_clk);
			i_setupStrobe = 1'b0;
			waited++;
		end while (!o_setupDone && waited < SETUP_WAIT);
		if (!o_setupDone) begin
			errorCount++;
			$display("o_setupDone never arrived after the setup strobe");
		end else begin
			checkValue("o_setupDone latency", waited, 2);
			checkValue("o_reject", int'(o_reject), p.rej);
			checkValue("o_clipMinX", int'(o_clipMinX), p.cMinX);
			checkValue("o_clipMaxX", int'(o_clipMaxX), p.cMaxX);
			checkValue("o_clipMinY", int'(o_clipMinY), p.cMinY);
			checkValue("o_clipMaxY", int'(o_clipMaxY), p.cMaxY);
		end
	endtask

	task automatic checkQuery(input primEntry_t p, input int px, input int py);
		int pxL;
		// Even member of the pair for either sign of X
		pxL = px & -2;
		checkValue("o_queryDone", int'(o_queryDone), 1);
		checkValue("o_validL", int'(o_validL), int'(modelCovered(p, pxL, py)));
		checkValue("o_validR", int'(o_validR), int'(modelCovered(p, pxL + 1, py)));
		if (p.isLine != 0) begin
			checkValue("o_lineInside", int'(o_lineInside), int'(lineInsideRef(p, px, py)));
		end
	endtask

	task automatic runQueries(input primEntry_t p);
		int qx [NUM_QUERIES];
		int qy [NUM_QUERIES];
		int baseX, baseY, r, k;
		qx[0] = p.qx0;
		qy[0] = p.qy0;
		qx[1] = p.qx1;
		qy[1] = p.qy1;
		// Random pixels near the v0/v1 corner reach outside the box too
		baseX = ((p.x0 < p.x1) ? p.x0 : p.x1) - 4;
		baseY = ((p.y0 < p.y1) ? p.y0 : p.y1) - 4;
		for (k = 2; k < NUM_QUERIES; k++) begin
			drawBits(6, r);
			qx[k] = baseX + r;
			drawBits(6, r);
			qy[k] = baseY + r;
		end
		// Query k is checked while query k+1 goes in
		for (k = 0; k < NUM_QUERIES; k++) begin
			i_queryStrobe = 1'b1;
			i_pixelX      = qx[k][11:0];
			i_pixelY      = qy[k][11:0];
			@(negedge i_clk);
			checkQuery(p, qx[k], qy[k]);
		end
		i_queryStrobe = 1'b0;
	endtask

	// Bresenham walk from v0 compared after every step
	task automatic walkLine(input primEntry_t p);
		int c, d, absC, absD, major, minor, err, sx, sy, px, py, n;
		bit yMajor;
		c      = p.x1 - p.x0;
		d      = p.y1 - p.y0;
		absC   = (c < 0) ? -c : c;
		absD   = (d < 0) ? -d : d;
		sx     = (c < 0) ? -1 : 1;
		sy     = (d < 0) ? -1 : 1;
		yMajor = absD > absC;
		major  = yMajor ? absD : absC;
		minor  = yMajor ? absC : absD;
		err    = yMajor ? 2 * minor : 2 * minor + 1;
		px     = p.x0;
		py     = p.y0;
		i_lineStart = 1'b1;
		@(negedge i_clk);
		i_lineStart = 1'b0;
		checkValue("o_lineX", int'(o_lineX), px);
		checkValue("o_lineY", int'(o_lineY), py);
		for (n = 0; n < major; n++) begin
			i_lineStep = 1'b1;
			@(negedge i_clk);
			if (err > major) begin
				px  = px + sx;
				py  = py + sy;
				err = err + 2 * minor - 2 * major;
			end else begin
				if (yMajor) begin
					py = py + sy;
				end else begin
					px = px + sx;
				end
				err = err + 2 * minor;
			end
			checkValue("o_lineX", int'(o_lineX), px);
			checkValue("o_lineY", int'(o_lineY), py);
		end
		i_lineStep = 1'b0;
		// Last point is v1
		checkValue("o_lineX at end", int'(o_lineX), p.x1);
		checkValue("o_lineY at end", int'(o_lineY), p.y1);
	endtask

	// ----------------------------------------
	// Main sequence and watchdog
	// ----------------------------------------
	initial begin
		int n;
		i_rst         = 1'b1;
		i_setupStrobe = 1'b0;
		i_isLine      = 1'b0;
		i_queryStrobe = 1'b0;
		i_lineStart   = 1'b0;
		i_lineStep    = 1'b0;
		i_x0          = '0;
		i_y0          = '0;
		i_x1          = '0;
		i_y1          = '0;
		i_x2          = '0;
		i_y2          = '0;
		i_pixelX      = '0;
		i_pixelY      = '0;
		i_areaX0      = '0;
		i_areaY0      = '0;
		i_areaX1      = '0;
		i_areaY1      = '0;
		lfsrState     = 16'd81;
		errorCount    = 0;
		checkCount    = 0;
		repeat (2) @(negedge i_clk);
		// Flags cleared by reset
		checkValue("o_setupDone", int'(o_setupDone), 0);
		checkValue("o_queryDone", int'(o_queryDone), 0);
		checkValue("o_reject", int'(o_reject), 0);
		checkValue("o_validL", int'(o_validL), 0);
		checkValue("o_validR", int'(o_validR), 0);
		checkValue("o_lineInside", int'(o_lineInside), 0);
		i_rst = 1'b0;
		for (n = 0; n < NUM_ENTRIES; n++) begin
			applySetup(primTable[n]);
			runQueries(primTable[n]);
			if (primTable[n].isLine != 0 && primTable[n].rej == 0) begin
				walkLine(primTable[n]);
			end
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* rasterSetup.f */
logic/rasterSetupPkg.sv
logic/triangleSetup.sv
logic/pixelBoxTest.sv
logic/coverageStage.sv
logic/lineStepper.sv
logic/rasterSetupUnit.sv
tb/rasterSetupUnit_props.sv
tb/rasterSetupTb.sv

/* Makefile */
# Verilator flow for the rasterizer setup unit

TOOL      = verilator
TOP       = rasterSetupTb
FILELIST  = rasterSetup.f
LINTFLAGS = --lint-only -Wall --timing
SIMFLAGS  = --binary --timing --assert -Wno-fatal
BUILDDIR  = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# Verdict comes from the log, not the exit code of the run
sim:
	$(TOOL) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
